//--- verilog/ls_pkg.sv
package ls_pkg;

    // buffer geometry
    localparam int lsbuf_size = 4;
    localparam int lsbuf_sel = 2;

    // data memory geometry, word addressed
    localparam int mem_words = 64;
    localparam int mem_addr_bits = 6;

    // one machine word
    typedef logic [31:0] data_t;

    // reservation tag naming a pending producer
    typedef logic [3:0] tag_t;

    // operand already present, also the dest of a store
    localparam tag_t tag_free = 4'd0;

    typedef enum logic [1:0] {
        op_nop = 2'd0,
        op_lw = 2'd1,
        op_sw = 2'd2
    } ls_op_e;

    // one decoded memory operation at allocation
    typedef struct packed {
        ls_op_e op;
        tag_t base_tag;
        data_t base;
        tag_t src_tag;
        data_t src;
        data_t imm;
        tag_t dest;
    } ls_entry_t;

    // one broadcast on a result bus
    typedef struct packed {
        logic valid;
        tag_t tag;
        data_t data;
    } result_t;

    // operation handed from the buffer to the execute unit
    // operands here are always resolved
    typedef struct packed {
        logic valid;
        ls_op_e op;
        data_t base;
        data_t imm;
        data_t src;
        tag_t dest;
    } ls_issue_t;

endpackage

//--- verilog/operand_capture.sv
module operand_capture (
    input ls_pkg::tag_t tag,
    input ls_pkg::data_t data,
    input ls_pkg::result_t alu_result,
    input ls_pkg::result_t mem_result,
    output ls_pkg::tag_t next_tag,
    output ls_pkg::data_t next_data
);

    always_comb begin
        next_tag = tag;
        next_data = data;
        // only a pending operand listens to the buses
        if (tag != ls_pkg::tag_free) begin
            if (alu_result.valid && (alu_result.tag == tag)) begin
                next_tag = ls_pkg::tag_free;
                next_data = alu_result.data;
            end else if (mem_result.valid && (mem_result.tag == tag)) begin
                next_tag = ls_pkg::tag_free;
                next_data = mem_result.data;
            end
        end
    end

    // a tag has one producer, so both buses never name it at once
    always_comb begin
        if (alu_result.valid && mem_result.valid) begin
            assert (alu_result.tag != mem_result.tag)
                else $error("alu and mem result buses carry the same tag %0d", alu_result.tag);
        end
    end

endmodule

//--- verilog/ls_buffer_entry.sv
module ls_buffer_entry (
    input logic clk,
    input logic rst,
    input logic alloc_en,
    input ls_pkg::ls_entry_t alloc,
    input ls_pkg::result_t alu_result,
    input ls_pkg::result_t mem_result,
    input logic busy,
    output logic ready,
    output ls_pkg::ls_issue_t slot
);

    ls_pkg::tag_t base_tag;
    ls_pkg::tag_t src_tag;
    ls_pkg::tag_t base_tag_nxt;
    ls_pkg::tag_t src_tag_nxt;
    ls_pkg::tag_t dest;
    ls_pkg::data_t base;
    ls_pkg::data_t src;
    ls_pkg::data_t imm;
    ls_pkg::data_t base_nxt;
    ls_pkg::data_t src_nxt;
    ls_pkg::ls_op_e op;

    operand_capture u_base_capture (
        .tag(base_tag),
        .data(base),
        .alu_result(alu_result),
        .mem_result(mem_result),
        .next_tag(base_tag_nxt),
        .next_data(base_nxt)
    );

    operand_capture u_src_capture (
        .tag(src_tag),
        .data(src),
        .alu_result(alu_result),
        .mem_result(mem_result),
        .next_tag(src_tag_nxt),
        .next_data(src_nxt)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_tag <= ls_pkg::tag_free;
            src_tag <= ls_pkg::tag_free;
        end else if (alloc_en) begin
            base_tag <= alloc.base_tag;
            src_tag <= alloc.src_tag;
        end else begin
            base_tag <= base_tag_nxt;
            src_tag <= src_tag_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            op <= alloc.op;
            base <= alloc.base;
            src <= alloc.src;
            imm <= alloc.imm;
            dest <= alloc.dest;
        end else begin
            base <= base_nxt;
            src <= src_nxt;
        end
    end

    // same-cycle captures count toward ready
    assign ready = busy && (base_tag_nxt == ls_pkg::tag_free) &&
                   (src_tag_nxt == ls_pkg::tag_free);

    always_comb begin
        slot.valid = 1'b0;
        slot.op = op;
        // bypassed values so a capture at issue is not lost
        slot.base = base_nxt;
        slot.imm = imm;
        slot.src = src_nxt;
        slot.dest = dest;
    end

endmodule

//--- verilog/ls_buffer.sv
module ls_buffer (
    input logic clk,
    input logic rst,
    input logic alloc_en,
    input ls_pkg::ls_entry_t alloc,
    input ls_pkg::result_t alu_result,
    input ls_pkg::result_t mem_result,
    input logic exec_idle,
    output ls_pkg::ls_issue_t issue,
    output logic lsbuf_free
);

    logic [ls_pkg::lsbuf_size-1:0] busy;
    logic [ls_pkg::lsbuf_size-1:0] ready;
    logic [ls_pkg::lsbuf_sel-1:0] alloc_ptr;
    logic [ls_pkg::lsbuf_sel-1:0] issue_ptr;
    logic [ls_pkg::lsbuf_sel:0] count;
    logic issue_en;
    ls_pkg::ls_issue_t slots [ls_pkg::lsbuf_size];

    assign lsbuf_free = count < (ls_pkg::lsbuf_sel + 1)'(ls_pkg::lsbuf_size);

    // exec_idle only drops one edge after the issue register loads,
    // so a pending issue blocks the next one
    assign issue_en = ready[issue_ptr] && exec_idle && !issue.valid;

    for (genvar i = 0; i < ls_pkg::lsbuf_size; i++) begin : g_entry
        ls_buffer_entry u_entry (
            .clk(clk),
            .rst(rst),
            .alloc_en(alloc_en && (alloc_ptr == (ls_pkg::lsbuf_sel)'(i))),
            .alloc(alloc),
            .alu_result(alu_result),
            .mem_result(mem_result),
            .busy(busy[i]),
            .ready(ready[i]),
            .slot(slots[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            alloc_ptr <= '0;
            issue_ptr <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                busy[alloc_ptr] <= 1'b1;
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            if (issue_en) begin
                busy[issue_ptr] <= 1'b0;
                issue_ptr <= issue_ptr + 1'b1;
            end
            // alloc and issue together keep the count
            case ({alloc_en, issue_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry goes out in order, bubble otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue <= '0;
        end else if (issue_en) begin
            issue <= slots[issue_ptr];
            issue.valid <= 1'b1;
        end else begin
            issue <= '0;
        end
    end

    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) alloc_en |-> lsbuf_free
    ) else $error("allocation while the load/store buffer is full");

    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= (ls_pkg::lsbuf_sel + 1)'(ls_pkg::lsbuf_size)
    ) else $error("buffer count %0d above depth", count);

endmodule

//--- verilog/ls_exec.sv
module ls_exec (
    input logic clk,
    input logic rst,
    input ls_pkg::ls_issue_t issue,
    output logic exec_idle,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output logic [ls_pkg::mem_addr_bits-1:0] wb_adr,
    output ls_pkg::data_t wb_dat_w,
    input ls_pkg::data_t wb_dat_r,
    input logic wb_ack,
    output ls_pkg::result_t mem_result
);

    typedef enum logic {
        ex_idle,
        ex_bus
    } ex_state_e;

    ex_state_e state;
    ls_pkg::data_t ea;
    ls_pkg::ls_op_e op_q;
    ls_pkg::tag_t dest_q;
    logic start;

    // word address from base plus offset
    assign ea = issue.base + issue.imm;
    assign start = (state == ex_idle) && issue.valid;
    assign exec_idle = (state == ex_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ex_idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            mem_result <= '0;
        end else begin
            mem_result <= '0;
            case (state)
                ex_idle: begin
                    if (issue.valid) begin
                        state <= ex_bus;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                ex_bus: begin
                    if (wb_ack) begin
                        state <= ex_idle;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        // stores end silently
                        if (op_q == ls_pkg::op_lw) begin
                            mem_result.valid <= 1'b1;
                            mem_result.tag <= dest_q;
                            mem_result.data <= wb_dat_r;
                        end
                    end
                end
                default: state <= ex_idle;
            endcase
        end
    end

    // bus payload, held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_we <= (issue.op == ls_pkg::op_sw);
            wb_adr <= ea[ls_pkg::mem_addr_bits-1:0];
            wb_dat_w <= issue.src;
            op_q <= issue.op;
            dest_q <= issue.dest;
        end
    end

    issue_only_when_idle: assert property (
        @(posedge clk) disable iff (rst) issue.valid |-> exec_idle
    ) else $error("issue arrived while the execute unit was busy");

endmodule

//--- verilog/data_ram.sv
module data_ram (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [ls_pkg::mem_addr_bits-1:0] wb_adr,
    input ls_pkg::data_t wb_dat_w,
    output ls_pkg::data_t wb_dat_r,
    output logic wb_ack
);

    ls_pkg::data_t mem [ls_pkg::mem_words];
    logic req;

    assign req = wb_cyc && wb_stb;

    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            mem[wb_adr] <= wb_dat_w;
        end
        if (req) begin
            wb_dat_r <= mem[wb_adr];
        end
    end

    // one ack per strobe, low again while the master drops stb
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req && !wb_ack;
        end
    end

endmodule

//--- verilog/ls_unit_top.sv
module ls_unit_top (
    input logic clk,
    input logic rst,
    input logic alloc_en,
    input ls_pkg::ls_entry_t alloc,
    input ls_pkg::result_t alu_result,
    output logic lsbuf_free,
    output ls_pkg::result_t mem_result
);

    ls_pkg::ls_issue_t issue;
    logic exec_idle;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [ls_pkg::mem_addr_bits-1:0] wb_adr;
    ls_pkg::data_t wb_dat_w;
    ls_pkg::data_t wb_dat_r;
    logic wb_ack;

    ls_buffer u_buffer (
        .clk(clk),
        .rst(rst),
        .alloc_en(alloc_en),
        .alloc(alloc),
        .alu_result(alu_result),
        .mem_result(mem_result),
        .exec_idle(exec_idle),
        .issue(issue),
        .lsbuf_free(lsbuf_free)
    );

    ls_exec u_exec (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .exec_idle(exec_idle),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .mem_result(mem_result)
    );

    data_ram u_ram (
        .clk(clk),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

endmodule

//--- verification/ls_unit_tb.sv
module ls_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_random = 48;
    localparam int n_ops = ls_pkg::mem_words + 13 + n_random;
    // per op: alloc, operand wait, four bus cycles, plus slack
    localparam int drain_cycles = 12;
    localparam int cycle_limit = 10 + n_ops * drain_cycles + 50;

    logic clk;
    logic rst;
    logic alloc_en;
    ls_pkg::ls_entry_t alloc;
    ls_pkg::result_t alu_result;
    logic lsbuf_free;
    ls_pkg::result_t mem_result;

    ls_pkg::data_t mem_model [ls_pkg::mem_words];
    ls_pkg::result_t exp_q [$];
    ls_pkg::result_t exp_head;
    logic [31:0] lfsr_state;
    int errors;
    int loads_checked;
    int cycles;

    ls_unit_top uut (
        .clk(clk),
        .rst(rst),
        .alloc_en(alloc_en),
        .alloc(alloc),
        .alu_result(alu_result),
        .lsbuf_free(lsbuf_free),
        .mem_result(mem_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic ls_pkg::data_t take_bits(input int n);
        ls_pkg::data_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic ls_pkg::data_t fill_word(input logic [ls_pkg::mem_addr_bits-1:0] a);
        return {a, 2'b01, a, 8'h5a, a, 4'h9};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic refresh_head();
        if (exp_q.size() != 0) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endtask

    // pending operands are driven inverted so only a capture gives the right value
    task automatic alloc_op(input ls_pkg::ls_op_e op, input ls_pkg::tag_t base_tag,
                            input ls_pkg::data_t base_val, input ls_pkg::tag_t src_tag,
                            input ls_pkg::data_t src_val, input ls_pkg::data_t imm,
                            input ls_pkg::tag_t dest);
        ls_pkg::data_t sum;
        logic [ls_pkg::mem_addr_bits-1:0] ea;
        ls_pkg::result_t res;
        sum = base_val + imm;
        ea = sum[ls_pkg::mem_addr_bits-1:0];
        while (!lsbuf_free) begin
            step();
        end
        alloc_en = 1'b1;
        alloc.op = op;
        alloc.base_tag = base_tag;
        alloc.base = (base_tag == ls_pkg::tag_free) ? base_val : ~base_val;
        alloc.src_tag = src_tag;
        alloc.src = (src_tag == ls_pkg::tag_free) ? src_val : ~src_val;
        alloc.imm = imm;
        alloc.dest = dest;
        if (op == ls_pkg::op_sw) begin
            mem_model[ea] = src_val;
        end else begin
            res.valid = 1'b1;
            res.tag = dest;
            res.data = mem_model[ea];
            exp_q.push_back(res);
            refresh_head();
        end
        step();
        alloc_en = 1'b0;
    endtask

    task automatic broadcast(input ls_pkg::tag_t tag, input ls_pkg::data_t data);
        alu_result.valid = 1'b1;
        alu_result.tag = tag;
        alu_result.data = data;
        step();
        alu_result = '0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    // retire the head once its result has been compared
    always @(posedge clk) begin
        if (!rst && mem_result.valid && (exp_q.size() != 0)) begin
            void'(exp_q.pop_front());
            loads_checked++;
            refresh_head();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles, the DUT hangs", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> lsbuf_free && !mem_result.valid
    ) else begin
        errors++;
        $display("ERROR %0t: outputs not idle after reset", $time);
    end

    result_tag_ok: assert property (
        @(posedge clk) disable iff (rst)
        mem_result.valid |-> exp_head.valid && (mem_result.tag == exp_head.tag)
    ) else begin
        errors++;
        $display("ERROR %0t: result tag %0d, expected tag %0d (pending %0d)", $time,
                 $sampled(mem_result.tag), $sampled(exp_head.tag), $sampled(exp_head.valid));
    end

    result_data_ok: assert property (
        @(posedge clk) disable iff (rst)
        mem_result.valid && exp_head.valid |-> mem_result.data == exp_head.data
    ) else begin
        errors++;
        $display("ERROR %0t: result data %h, expected %h", $time,
                 $sampled(mem_result.data), $sampled(exp_head.data));
    end

    initial begin
        ls_pkg::data_t r;
        ls_pkg::data_t base_val;
        ls_pkg::data_t src_val;
        ls_pkg::data_t imm;
        ls_pkg::tag_t tag;
        logic is_load;
        logic pending;
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc = '0;
        alu_result = '0;
        exp_head = '0;
        lfsr_state = 32'h10a7aa28;
        errors = 0;
        loads_checked = 0;
        cycles = 0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        // quiet bus with nothing allocated
        repeat (4) step();

        for (int a = 0; a < ls_pkg::mem_words; a++) begin
            alloc_op(ls_pkg::op_sw, ls_pkg::tag_free, 32'd0, ls_pkg::tag_free,
                     fill_word(6'(a)), 32'(a), ls_pkg::tag_free);
        end

        // store then load of the same word
        r = take_bits(32);
        alloc_op(ls_pkg::op_sw, ls_pkg::tag_free, 32'h100, ls_pkg::tag_free, r, 32'd5,
                 ls_pkg::tag_free);
        alloc_op(ls_pkg::op_lw, ls_pkg::tag_free, 32'h100, ls_pkg::tag_free, 32'd0, 32'd5, 4'd8);

        // broadcast while the lone entry is checked for issue
        drain();
        alloc_op(ls_pkg::op_lw, 4'd2, 32'h40, ls_pkg::tag_free, 32'd0, 32'd7, 4'd9);
        broadcast(4'd2, 32'h40);
        src_val = take_bits(32);
        alloc_op(ls_pkg::op_sw, ls_pkg::tag_free, 32'd20, 4'd3, src_val, 32'd0,
                 ls_pkg::tag_free);
        repeat (3) step();
        broadcast(4'd3, src_val);
        alloc_op(ls_pkg::op_lw, ls_pkg::tag_free, 32'd18, ls_pkg::tag_free, 32'd0, 32'd2, 4'd10);

        // base taken from the memory result bus
        drain();
        alloc_op(ls_pkg::op_lw, ls_pkg::tag_free, 32'd0, ls_pkg::tag_free, 32'd0, 32'd12, 4'd11);
        alloc_op(ls_pkg::op_lw, 4'd11, mem_model[12], ls_pkg::tag_free, 32'd0, 32'd3, 4'd12);

        // fill the buffer behind one missing tag
        drain();
        base_val = take_bits(32);
        for (int k = 0; k < ls_pkg::lsbuf_size; k++) begin
            alloc_op(ls_pkg::op_lw, 4'd5, base_val, ls_pkg::tag_free, 32'd0, 32'(k * 9),
                     4'(12 + k));
        end
        assert (lsbuf_free == 1'b0) else begin
            errors++;
            $display("ERROR %0t: lsbuf_free high with a full buffer", $time);
        end
        repeat (4) step();
        broadcast(4'd5, base_val);
        drain();
        assert (lsbuf_free == 1'b1) else begin
            errors++;
            $display("ERROR %0t: lsbuf_free low after the buffer drained", $time);
        end

        for (int i = 0; i < n_random; i++) begin
            r = take_bits(1);
            is_load = r[0];
            r = take_bits(1);
            pending = r[0];
            base_val = take_bits(32);
            imm = take_bits(6);
            src_val = take_bits(32);
            tag = pending ? 4'(1 + (i % 7)) : ls_pkg::tag_free;
            if (is_load) begin
                alloc_op(ls_pkg::op_lw, tag, base_val, ls_pkg::tag_free, 32'd0, imm,
                         4'(8 + (i % 8)));
            end else begin
                alloc_op(ls_pkg::op_sw, tag, base_val, ls_pkg::tag_free, src_val, imm,
                         ls_pkg::tag_free);
            end
            if (pending) begin
                r = take_bits(2);
                repeat (r) step();
                broadcast(tag, base_val);
            end
        end
        drain();

        $display("checked %0d load results, %0d errors", loads_checked, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/ls_pkg.sv
verilog/operand_capture.sv
verilog/ls_buffer_entry.sv
verilog/ls_buffer.sv
verilog/ls_exec.sv
verilog/data_ram.sv
verilog/ls_unit_top.sv
verification/ls_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module ls_unit_tb \
    -f filelist.f \
    --Mdir obj_dir \
    -o ls_unit_sim

./obj_dir/ls_unit_sim | tee "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
